// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import riscvPkg::*; (
	input word a,
	input word b,
	input aluOp op,
	output word y
);

	logic [4:0] shamt;

	// shifts only look at the low five bits
	assign shamt = b[4:0];

	always_comb begin
		case (op)
			aluAdd: y = a + b;
			aluSub: y = a - b;
			aluAnd: y = a & b;
			aluOr: y = a | b;
			aluXor: y = a ^ b;
			aluSlt: y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			aluSltu: y = {{(xlen-1){1'b0}}, a < b};
			aluSll: y = a << shamt;
			aluSrl: y = a >> shamt;
			aluSra: y = $signed(a) >>> shamt;
			aluPassB: y = b;
			default: y = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: branchResolve.sv
`timescale 1ns/1ps
`default_nettype none

module branchResolve import riscvPkg::*; (
	input word pc,
	input word imm,
	input word a,
	input word b,
	input memWidth funct3,
	input logic isBranch,
	output logic taken,
	output word target
);

	logic cond;

	always_comb begin
		case (funct3)
			3'b000: cond = a == b;
			3'b001: cond = a != b;
			3'b100: cond = $signed(a) < $signed(b);
			3'b101: cond = $signed(a) >= $signed(b);
			3'b110: cond = a < b;
			3'b111: cond = a >= b;
			default: cond = 1'b0;
		endcase
	end

	assign taken = isBranch && cond;
	assign target = pc + imm;

endmodule

`default_nettype wire

// File: controlDecode.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecode import riscvPkg::*; (
	input word instr,
	output aluOp aluCtl,
	output word imm,
	output opASel aSel,
	output logic bIsImm,
	output logic regWrite,
	output logic isBranch,
	output logic isJump,
	output logic isLoad,
	output logic isStore,
	output wbSel wb,
	output memWidth width
);

	immKind kind;
	memWidth funct3;

	function automatic aluOp arith(input memWidth f3, input logic alt);
		case (f3)
			3'b000: return alt ? aluSub : aluAdd;
			3'b001: return aluSll;
			3'b010: return aluSlt;
			3'b011: return aluSltu;
			3'b100: return aluXor;
			3'b101: return alt ? aluSra : aluSrl;
			3'b110: return aluOr;
			default: return aluAnd;
		endcase
	endfunction

	assign funct3 = funct3Of(instr);
	assign width = funct3;

	always_comb begin
		aluCtl = aluAdd;
		aSel = opARs1;
		bIsImm = 1'b1;
		regWrite = 1'b0;
		isBranch = 1'b0;
		isJump = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		wb = wbAlu;
		kind = immI;
		case (opOf(instr))
			op: begin
				bIsImm = 1'b0;
				regWrite = 1'b1;
				aluCtl = arith(funct3, instr[30]);
			end
			opImm: begin
				regWrite = 1'b1;
				// bit 30 is part of the immediate except for SRAI
				aluCtl = arith(funct3, funct3 == 3'b101 && instr[30]);
			end
			load: begin
				regWrite = 1'b1;
				isLoad = 1'b1;
				wb = wbMem;
			end
			store: begin
				isStore = 1'b1;
				kind = immS;
			end
			branch: begin
				isBranch = 1'b1;
				kind = immB;
			end
			lui: begin
				regWrite = 1'b1;
				aSel = opAZero;
				aluCtl = aluPassB;
				kind = immU;
			end
			auipc: begin
				regWrite = 1'b1;
				aSel = opAPc;
				kind = immU;
			end
			jal: begin
				regWrite = 1'b1;
				isJump = 1'b1;
				aSel = opAPc;
				wb = wbPcPlus4;
				kind = immJ;
			end
			jalr: begin
				regWrite = 1'b1;
				isJump = 1'b1;
				wb = wbPcPlus4;
			end
			// anything else passes as a bubble
			default: bIsImm = 1'b0;
		endcase
	end

	always_comb begin
		case (kind)
			immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			immB: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			immU: imm = {instr[31:12], 12'b0};
			immJ: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			default: imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

endmodule

`default_nettype wire

// File: coreTb.sv
`timescale 1ns/1ps
`default_nettype none

module coreTb import riscvPkg::*; ();

	logic clk;
	logic reset;
	word instr;
	word din;
	word pc;
	word memAdr;
	word memWdata;
	byteMask wea;

	word imem [0:1023];
	logic [7:0] dmem [0:4095];
	logic [7:0] refMem [0:4095];
	word rf [0:31];
	word expAddr [$];
	word expData [$];
	byteMask expMask [$];
	word rng;
	word endPc;
	int wp;
	int sOff;
	int execCount;
	int seen;
	int loopFetches;
	logic refDone;

	tbClock tbClock_inst (.clk(clk), .reset(reset));

	dataPath #(.resetPc(32'h0)) dataPath_inst (
		.clk(clk), .reset(reset), .instr(instr), .din(din),
		.pc(pc), .memAdr(memAdr), .memWdata(memWdata), .wea(wea)
	);

	function automatic word xorshift(input word x);
		word s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	function automatic word rand32();
		rng = xorshift(rng);
		return rng;
	endfunction

	// initial memory contents that mix every address bit
	function automatic logic [7:0] fillByte(input int a);
		return a[7:0] ^ {a[3:0], a[11:8]} ^ 8'h5a;
	endfunction

	function automatic word encR(input int alt, input int rs2, input int rs1, input int f3,
			input int rd);
		return {1'b0, alt[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic word encI(input int imm, input int rs1, input int f3, input int rd,
			input opcode opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic word encS(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], store};
	endfunction

	function automatic word encB(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], branch};
	endfunction

	function automatic word encU(input int imm20, input int rd, input opcode opc);
		return {imm20[19:0], rd[4:0], opc};
	endfunction

	function automatic word encJ(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], jal};
	endfunction

	task automatic emit(input word w);
		imem[wp] = w;
		wp++;
	endtask

	task automatic loadImm(input int rd, input word v);
		word upper;
		upper = (v + 32'h800) >> 12;
		emit(encU(upper, rd, lui));
		emit(encI(v, rd, 0, rd, opImm));
	endtask

	// each store gets its own word slot
	task automatic storeReg(input int rs, input int f3, input int lane);
		emit(encS(sOff + lane, rs, 0, f3));
		sOff += 4;
	endtask

	task automatic buildProgram();
		word a;
		word b;
		int w3;
		int off;
		int sw3;
		int lane;
		int bf3 [0:5];
		bf3 = '{0, 1, 4, 5, 6, 7};
		for (int i = 0; i < 1024; i++)
			imem[i] = encJ(0, 0);
		wp = 0;
		sOff = 1024;
		// register and immediate ALU operations
		for (int k = 0; k < 3; k++) begin
			loadImm(1, rand32());
			loadImm(2, rand32());
			for (int f = 0; f < 8; f++) begin
				emit(encR(0, 2, 1, f, 3));
				storeReg(3, 2, 0);
			end
			emit(encR(1, 2, 1, 0, 3));
			storeReg(3, 2, 0);
			emit(encR(1, 2, 1, 5, 3));
			storeReg(3, 2, 0);
			for (int f = 0; f < 8; f++) begin
				if (f == 1 || f == 5)
					emit(encI(rand32() & 32'h1f, 1, f, 3, opImm));
				else
					emit(encI(rand32(), 1, f, 3, opImm));
				storeReg(3, 2, 0);
			end
			// srai
			emit(encI(32'h400 | (rand32() & 32'h1f), 1, 5, 3, opImm));
			storeReg(3, 2, 0);
			emit(encU(rand32(), 3, lui));
			storeReg(3, 2, 0);
			emit(encU(rand32(), 3, auipc));
			storeReg(3, 2, 0);
		end
		// back-to-back dependencies
		emit(encR(0, 2, 1, 0, 4));
		emit(encR(0, 1, 4, 0, 5));
		emit(encR(1, 4, 5, 0, 6));
		storeReg(6, 2, 0);
		storeReg(5, 2, 0);
		emit(encR(0, 6, 4, 4, 7));
		storeReg(7, 2, 0);
		// loads with a dependent store right behind
		for (int k = 0; k < 10; k++) begin
			loadImm(8, rand32() & 32'h3f0);
			case (k % 5)
				0: w3 = 0;
				1: w3 = 1;
				2: w3 = 2;
				3: w3 = 4;
				default: w3 = 5;
			endcase
			off = rand32() & 32'hc;
			if (w3 == 0 || w3 == 4)
				off = off | (rand32() & 32'h3);
			else if (w3 == 1 || w3 == 5)
				off = off | (rand32() & 32'h2);
			emit(encI(off, 8, w3, 15, load));
			sw3 = k % 3;
			lane = (sw3 == 0) ? (rand32() & 32'h3) : (sw3 == 1) ? (rand32() & 32'h2) : 0;
			storeReg(15, sw3, lane);
			emit(encR(0, 15, 15, 0, 16));
			storeReg(16, 2, 0);
		end
		// branches on plain, just-computed and just-loaded operands
		for (int k = 0; k < 24; k++) begin
			a = rand32();
			b = (k % 4 < 2) ? a : rand32();
			loadImm(1, a);
			loadImm(2, b);
			if (k % 3 == 1) begin
				emit(encI(0, 1, 0, 1, opImm));
			end else if (k % 3 == 2) begin
				emit(encS(2040, 1, 0, 2));
				emit(encI(2040, 0, 2, 1, load));
			end
			emit(encB(12, 2, 1, bf3[k % 6]));
			emit(encI(k + 1, 0, 0, 9, opImm));
			storeReg(9, 2, 0);
			emit(encI(k + 100, 0, 0, 10, opImm));
			storeReg(10, 2, 0);
		end
		// jal and jalr
		emit(encJ(12, 11));
		emit(encI(77, 0, 0, 12, opImm));
		storeReg(12, 2, 0);
		storeReg(11, 2, 0);
		emit(encU(0, 13, auipc));
		// bit 0 of this odd target is dropped
		emit(encI(17, 13, 0, 14, jalr));
		emit(encI(55, 0, 0, 12, opImm));
		storeReg(12, 2, 0);
		storeReg(14, 2, 0);
		storeReg(13, 2, 0);
		emit(encJ(0, 0));
	endtask

	function automatic word arithRef(input logic [2:0] f3, input logic alt, input word a,
			input word b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? word'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// sequential RV32I model that retires one instruction per loop pass
	function automatic int runReference();
		word p;
		word nextP;
		word ins;
		word a;
		word b;
		word res;
		word addr;
		word val;
		word immI;
		word immS;
		word immB;
		word immJ;
		logic [2:0] f3;
		logic [4:0] rd;
		logic [1:0] lane;
		logic [11:0] wa;
		byteMask m;
		logic wr;
		logic take;
		int n;
		for (int i = 0; i < 32; i++)
			rf[i] = '0;
		p = '0;
		n = 0;
		while (imem[p[11:2]] != encJ(0, 0) && n < 20000) begin
			ins = imem[p[11:2]];
			f3 = ins[14:12];
			rd = ins[11:7];
			a = rf[ins[19:15]];
			b = rf[ins[24:20]];
			immI = {{20{ins[31]}}, ins[31:20]};
			immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			res = '0;
			wr = 1'b0;
			nextP = p + 4;
			case (ins[6:0])
				7'b0110011: begin
					res = arithRef(f3, ins[30], a, b);
					wr = 1'b1;
				end
				7'b0010011: begin
					res = arithRef(f3, f3 == 3'd5 && ins[30], a, immI);
					wr = 1'b1;
				end
				7'b0000011: begin
					addr = a + immI;
					wa = {addr[11:2], 2'b00};
					val = {refMem[wa + 3], refMem[wa + 2], refMem[wa + 1], refMem[wa]};
					val = val >> {addr[1:0], 3'b000};
					case (f3)
						3'd0: res = {{24{val[7]}}, val[7:0]};
						3'd1: res = {{16{val[15]}}, val[15:0]};
						3'd4: res = {24'b0, val[7:0]};
						3'd5: res = {16'b0, val[15:0]};
						default: res = val;
					endcase
					wr = 1'b1;
				end
				7'b0100011: begin
					addr = a + immS;
					lane = addr[1:0];
					if (f3 == 3'd0)
						m = 4'b0001 << lane;
					else if (f3 == 3'd1)
						m = 4'b0011 << lane;
					else
						m = 4'b1111;
					val = b << {lane, 3'b000};
					for (int j = 0; j < 4; j++)
						if (m[j])
							refMem[{addr[11:2], 2'(j)}] = val[8*j +: 8];
					expAddr.push_back({addr[31:2], 2'b00});
					expData.push_back(val);
					expMask.push_back(m);
				end
				7'b1100011: begin
					case (f3)
						3'd0: take = a == b;
						3'd1: take = a != b;
						3'd4: take = $signed(a) < $signed(b);
						3'd5: take = $signed(a) >= $signed(b);
						3'd6: take = a < b;
						default: take = a >= b;
					endcase
					if (take)
						nextP = p + immB;
				end
				7'b0110111: begin
					res = {ins[31:12], 12'b0};
					wr = 1'b1;
				end
				7'b0010111: begin
					res = p + {ins[31:12], 12'b0};
					wr = 1'b1;
				end
				7'b1101111: begin
					res = p + 4;
					wr = 1'b1;
					nextP = p + immJ;
				end
				7'b1100111: begin
					res = p + 4;
					wr = 1'b1;
					nextP = (a + immI) & ~32'd1;
				end
				default: wr = 1'b0;
			endcase
			if (wr && rd != 5'd0)
				rf[rd] = res;
			p = nextP;
			n++;
		end
		return n;
	endfunction

	function automatic word laneBits(input byteMask m);
		return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
	endfunction

	task automatic failRun();
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic stopRun(input string msg);
		$display("%s at %0t ns", msg, $time);
		failRun();
	endtask

	task automatic checkAddr(input string name, input word got, input word exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
			failRun();
		end
	endtask

	task automatic checkData(input string name, input word got, input word exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
			failRun();
		end
	endtask

	task automatic checkMask(input string name, input byteMask got, input byteMask exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
			failRun();
		end
	endtask

	initial begin
		instr = '0;
		din = '0;
		rng = 32'h70e8;
		refDone = 1'b0;
		seen = 0;
		loopFetches = 0;
		for (int i = 0; i < 4096; i++) begin
			dmem[i] = fillByte(i);
			refMem[i] = fillByte(i);
		end
		buildProgram();
		// the program closes with a self-loop jump
		endPc = 4 * (wp - 1);
		execCount = runReference();
		refDone = 1'b1;
	end

	// memories answer a little after the clock edge
	always @(posedge clk) begin
		#1;
		instr = imem[pc[11:2]];
		din = {dmem[{memAdr[11:2], 2'd3}], dmem[{memAdr[11:2], 2'd2}],
			dmem[{memAdr[11:2], 2'd1}], dmem[{memAdr[11:2], 2'd0}]};
	end

	// every store strobe is matched against the reference in mid-cycle
	always @(negedge clk) begin
		if (refDone && wea != '0) begin
			if (reset) begin
				stopRun("store strobe raised during reset");
			end else if (seen >= expAddr.size()) begin
				stopRun("unexpected store beyond the expected list");
			end else begin
				checkAddr("memAdr", {memAdr[31:2], 2'b00}, expAddr[seen]);
				checkMask("wea", wea, expMask[seen]);
				checkData("memWdata", memWdata & laneBits(wea),
					expData[seen] & laneBits(expMask[seen]));
				for (int j = 0; j < 4; j++)
					if (wea[j])
						dmem[{memAdr[11:2], 2'(j)}] = memWdata[8*j +: 8];
				seen++;
			end
		end else if (refDone && seen == expAddr.size() && pc == endPc) begin
			// fetched again only after the closing jump has redirected
			loopFetches++;
			if (loopFetches == 2) begin
				$display("Verification passed");
				$finish;
			end
		end
	end

	initial begin
		wait (refDone);
		#(40 * (4 * execCount + 20));
		stopRun("timeout waiting for the expected stores");
	end

endmodule

`default_nettype wire

// File: dataPath.sv
`timescale 1ns/1ps
`default_nettype none

module dataPath import riscvPkg::*; #(
	parameter word resetPc = '0
) (
	input logic clk,
	input logic reset,
	input word instr,
	input word din,
	output word pc,
	output word memAdr,
	output word memWdata,
	output byteMask wea
);

	word pcF, pcNext, pcPlus4F;
	word instrD, pcD, pcPlus4D, rs1D, rs2D, immD, brA, brB, branchTarget;
	aluOp aluCtlD;
	opASel aSelD;
	wbSel wbD;
	memWidth widthD;
	logic bIsImmD, regWriteD, isBranchD, isJumpD, isLoadD, isStoreD, branchTaken;
	word pcE, pcPlus4E, rs1ValE, rs2ValE, immE, fwdValA, fwdValB;
	word opA, opB, aluY, jumpTarget;
	aluOp aluCtlE;
	opASel aSelE;
	wbSel wbE;
	memWidth widthE;
	regAddr rs1AddrE, rs2AddrE, rdE;
	logic bIsImmE, regWriteE, isLoadE, isStoreE, jumpE;
	word aluM, storeDataM, pcPlus4M, resultM, loadDataM;
	wbSel wbM;
	memWidth widthM;
	regAddr rdM;
	logic regWriteM, isLoadM, isStoreM;
	word aluW, loadW, pcPlus4W, resultW;
	wbSel wbW;
	regAddr rdW;
	logic regWriteW;
	logic stallF, stallD, flushD, flushE, brFwdA, brFwdB;
	fwdSel fwdA, fwdB;

	// a jump in execute overrides a branch in decode
	assign pcPlus4F = pcF + 32'd4;
	always_comb begin
		if (jumpE)
			pcNext = jumpTarget;
		else if (branchTaken && !stallD)
			pcNext = branchTarget;
		else
			pcNext = pcPlus4F;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pcF <= resetPc;
		else if (!stallF)
			pcF <= pcNext;
	end
	assign pc = pcF;

	// an all-zero word decodes as a bubble
	always_ff @(posedge clk) begin
		if (reset || flushD)
			instrD <= '0;
		else if (!stallD)
			instrD <= instr;
	end
	always_ff @(posedge clk) begin
		if (!stallD) begin
			pcD <= pcF;
			pcPlus4D <= pcPlus4F;
		end
	end

	regFile regFile_inst (
		.clk(clk), .reset(reset), .we(regWriteW), .rdAddr(rdW),
		.rs1Addr(rs1Of(instrD)), .rs2Addr(rs2Of(instrD)), .wd(resultW),
		.rs1(rs1D), .rs2(rs2D)
	);

	controlDecode controlDecode_inst (
		.instr(instrD), .aluCtl(aluCtlD), .imm(immD), .aSel(aSelD), .bIsImm(bIsImmD),
		.regWrite(regWriteD), .isBranch(isBranchD), .isJump(isJumpD), .isLoad(isLoadD),
		.isStore(isStoreD), .wb(wbD), .width(widthD)
	);

	assign brA = brFwdA ? resultM : rs1D;
	assign brB = brFwdB ? resultM : rs2D;

	branchResolve branchResolve_inst (
		.pc(pcD), .imm(immD), .a(brA), .b(brB), .funct3(widthD), .isBranch(isBranchD),
		.taken(branchTaken), .target(branchTarget)
	);

	always_ff @(posedge clk) begin
		if (reset || flushE) begin
			regWriteE <= 1'b0;
			isLoadE <= 1'b0;
			isStoreE <= 1'b0;
			jumpE <= 1'b0;
		end else begin
			regWriteE <= regWriteD;
			isLoadE <= isLoadD;
			isStoreE <= isStoreD;
			jumpE <= isJumpD;
		end
	end
	always_ff @(posedge clk) begin
		aluCtlE <= aluCtlD;
		aSelE <= aSelD;
		bIsImmE <= bIsImmD;
		wbE <= wbD;
		widthE <= widthD;
		rs1AddrE <= rs1Of(instrD);
		rs2AddrE <= rs2Of(instrD);
		rdE <= rdOf(instrD);
		rs1ValE <= rs1D;
		rs2ValE <= rs2D;
		immE <= immD;
		pcE <= pcD;
		pcPlus4E <= pcPlus4D;
	end

	always_comb begin
		case (fwdA)
			fwdMem: fwdValA = resultM;
			fwdWb: fwdValA = resultW;
			default: fwdValA = rs1ValE;
		endcase
		case (fwdB)
			fwdMem: fwdValB = resultM;
			fwdWb: fwdValB = resultW;
			default: fwdValB = rs2ValE;
		endcase
		case (aSelE)
			opAPc: opA = pcE;
			opAZero: opA = '0;
			default: opA = fwdValA;
		endcase
	end
	assign opB = bIsImmE ? immE : fwdValB;

	alu alu_inst (.a(opA), .b(opB), .op(aluCtlE), .y(aluY));

	// JALR drops bit 0, JAL targets are already even
	assign jumpTarget = {aluY[xlen-1:1], 1'b0};

	always_ff @(posedge clk) begin
		if (reset) begin
			regWriteM <= 1'b0;
			isLoadM <= 1'b0;
			isStoreM <= 1'b0;
		end else begin
			regWriteM <= regWriteE;
			isLoadM <= isLoadE;
			isStoreM <= isStoreE;
		end
	end
	always_ff @(posedge clk) begin
		aluM <= aluY;
		storeDataM <= fwdValB;
		pcPlus4M <= pcPlus4E;
		wbM <= wbE;
		widthM <= widthE;
		rdM <= rdE;
	end

	// loads in memory are never forwarded, the hazard unit stalls instead
	assign resultM = (wbM == wbPcPlus4) ? pcPlus4M : aluM;
	assign memAdr = aluM;

	loadStoreAlign loadStoreAlign_inst (
		.addrLow(aluM[1:0]), .width(widthM), .isStore(isStoreM), .isLoad(isLoadM),
		.storeData(storeDataM), .din(din), .wea(wea), .wdata(memWdata), .loadData(loadDataM)
	);

	always_ff @(posedge clk) begin
		if (reset)
			regWriteW <= 1'b0;
		else
			regWriteW <= regWriteM;
	end
	always_ff @(posedge clk) begin
		aluW <= aluM;
		loadW <= loadDataM;
		pcPlus4W <= pcPlus4M;
		wbW <= wbM;
		rdW <= rdM;
	end

	always_comb begin
		case (wbW)
			wbMem: resultW = loadW;
			wbPcPlus4: resultW = pcPlus4W;
			default: resultW = aluW;
		endcase
	end

	hazardUnit hazardUnit_inst (
		.rs1D(rs1Of(instrD)), .rs2D(rs2Of(instrD)), .rs1E(rs1AddrE), .rs2E(rs2AddrE),
		.rdE(rdE), .rdM(rdM), .rdW(rdW), .isBranchD(isBranchD), .regWriteE(regWriteE),
		.regWriteM(regWriteM), .regWriteW(regWriteW), .isLoadE(isLoadE), .isLoadM(isLoadM),
		.jumpE(jumpE), .branchTakenD(branchTaken), .stallF(stallF), .stallD(stallD),
		.flushD(flushD), .flushE(flushE), .brFwdA(brFwdA), .brFwdB(brFwdB),
		.fwdA(fwdA), .fwdB(fwdB)
	);

endmodule

`default_nettype wire

// File: hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import riscvPkg::*; (
	input regAddr rs1D,
	input regAddr rs2D,
	input regAddr rs1E,
	input regAddr rs2E,
	input regAddr rdE,
	input regAddr rdM,
	input regAddr rdW,
	input logic isBranchD,
	input logic regWriteE,
	input logic regWriteM,
	input logic regWriteW,
	input logic isLoadE,
	input logic isLoadM,
	input logic jumpE,
	input logic branchTakenD,
	output logic stallF,
	output logic stallD,
	output logic flushD,
	output logic flushE,
	output logic brFwdA,
	output logic brFwdB,
	output fwdSel fwdA,
	output fwdSel fwdB
);

	logic loadUse;
	logic branchStall;
	logic stall;

	function automatic logic hits(input regAddr rd, input regAddr rs);
		return rd != '0 && rd == rs;
	endfunction

	// memory stage is newer than writeback, so it wins
	function automatic fwdSel pickFwd(input regAddr rs, input logic wrM, input regAddr dstM,
			input logic wrW, input regAddr dstW);
		if (wrM && hits(dstM, rs))
			return fwdMem;
		if (wrW && hits(dstW, rs))
			return fwdWb;
		return fwdNone;
	endfunction

	assign loadUse = isLoadE && (hits(rdE, rs1D) || hits(rdE, rs2D));
	assign branchStall = isBranchD && ((regWriteE && (hits(rdE, rs1D) || hits(rdE, rs2D)))
		|| (isLoadM && (hits(rdM, rs1D) || hits(rdM, rs2D))));

	// a jump in execute squashes decode, nothing there needs to wait
	assign stall = (loadUse || branchStall) && !jumpE;
	assign stallF = stall;
	assign stallD = stall;
	assign flushD = jumpE || (branchTakenD && !stall);
	assign flushE = jumpE || stall;

	assign brFwdA = regWriteM && !isLoadM && hits(rdM, rs1D);
	assign brFwdB = regWriteM && !isLoadM && hits(rdM, rs2D);
	assign fwdA = pickFwd(rs1E, regWriteM, rdM, regWriteW, rdW);
	assign fwdB = pickFwd(rs2E, regWriteM, rdM, regWriteW, rdW);

endmodule

`default_nettype wire

// File: loadStoreAlign.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreAlign import riscvPkg::*; (
	input logic [1:0] addrLow,
	input memWidth width,
	input logic isStore,
	input logic isLoad,
	input word storeData,
	input word din,
	output byteMask wea,
	output word wdata,
	output word loadData
);

	logic [4:0] laneShift;
	word shifted;

	assign laneShift = {addrLow, 3'b000};
	assign wdata = storeData << laneShift;
	// addressed byte or halfword lands in the low lanes
	assign shifted = din >> laneShift;

	always_comb begin
		wea = '0;
		if (isStore) begin
			case (width[1:0])
				2'b00: wea = 4'b0001 << addrLow;
				2'b01: wea = addrLow[1] ? 4'b1100 : 4'b0011;
				default: wea = 4'b1111;
			endcase
		end
	end

	always_comb begin
		loadData = '0;
		if (isLoad) begin
			case (width)
				3'b000: loadData = {{24{shifted[7]}}, shifted[7:0]};
				3'b100: loadData = {24'b0, shifted[7:0]};
				3'b001: loadData = {{16{shifted[15]}}, shifted[15:0]};
				3'b101: loadData = {16'b0, shifted[15:0]};
				default: loadData = din;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import riscvPkg::*; (
	input logic clk,
	input logic reset,
	input logic we,
	input regAddr rdAddr,
	input regAddr rs1Addr,
	input regAddr rs2Addr,
	input word wd,
	output word rs1,
	output word rs2
);

	// no storage behind x0
	word regs [1:31];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rdAddr != '0) begin
			regs[rdAddr] <= wd;
		end
	end

	// write-through so decode sees the value written back this cycle
	always_comb begin
		if (rs1Addr == '0)
			rs1 = '0;
		else if (we && rs1Addr == rdAddr)
			rs1 = wd;
		else
			rs1 = regs[rs1Addr];
		if (rs2Addr == '0)
			rs2 = '0;
		else if (we && rs2Addr == rdAddr)
			rs2 = wd;
		else
			rs2 = regs[rs2Addr];
	end

endmodule

`default_nettype wire

// File: riscvPkg.sv
`default_nettype none

package riscvPkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word;
	typedef logic [4:0] regAddr;
	typedef logic [3:0] byteMask;
	// load or store funct3 where bit 2 set means zero-extend
	typedef logic [2:0] memWidth;

	typedef enum logic [6:0] {
		op     = 7'b0110011,
		opImm  = 7'b0010011,
		load   = 7'b0000011,
		store  = 7'b0100011,
		branch = 7'b1100011,
		lui    = 7'b0110111,
		auipc  = 7'b0010111,
		jal    = 7'b1101111,
		jalr   = 7'b1100111
	} opcode;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt,
		aluSltu, aluSll, aluSrl, aluSra, aluPassB
	} aluOp;

	typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immKind;
	typedef enum logic [1:0] {opARs1, opAPc, opAZero} opASel;
	typedef enum logic [1:0] {wbAlu, wbMem, wbPcPlus4} wbSel;
	typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSel;

	function automatic opcode opOf(input word instr);
		return opcode'(instr[6:0]);
	endfunction

	function automatic regAddr rdOf(input word instr);
		return instr[11:7];
	endfunction

	function automatic regAddr rs1Of(input word instr);
		return instr[19:15];
	endfunction

	function automatic regAddr rs2Of(input word instr);
		return instr[24:20];
	endfunction

	function automatic memWidth funct3Of(input word instr);
		return instr[14:12];
	endfunction

endpackage

`default_nettype wire

// File: run.sh
#!/bin/bash
# builds the testbench with Verilator and runs it, exit status follows the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f tb.f --top-module coreTb -o coreSim && ./obj_dir/coreSim || exit 1

// File: tb.f
riscvPkg.sv
regFile.sv
controlDecode.sv
alu.sv
branchResolve.sv
hazardUnit.sv
loadStoreAlign.sv
dataPath.sv
tbClock.sv
coreTb.sv

// File: tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reset held for three rising edges
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire
